/* list.f */
+incdir+dv
hdl/wbh_pkg.sv
hdl/wbh_req_stage.sv
hdl/wbh_router.sv
hdl/wbh_regs.sv
hdl/wbh_top.sv
dv/tb_wbh.sv

/* run.sh */
#!/bin/sh
# build and run tb_wbh with Verilator; exit status follows the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_wbh -Mdir obj_dir -o tb_wbh -f list.f \
   && ./obj_dir/tb_wbh > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "=== PASS ===" sim.log && exit 0 || exit 1

/* dv/tb_wbh_tests.svh */
// directed tests included inside tb_wbh; they use its signals, host_xfer, slave model and compare tasks

localparam wb_addr_t REG_BASE = 32'h0008_0000;   // bits 19:18 = 10
localparam wb_addr_t RSV_BASE = 32'h000C_0000;   // bits 19:18 = 11

function automatic wb_addr_t reg_adr(input reg_idx_t idx);
   return REG_BASE + {28'd0, idx, 2'b00};   // word index at bits 3:2
endfunction

task automatic reg_write(input reg_idx_t idx, input wb_data_t dat, input wb_sel_t sel);
   wb_data_t rdat;
   logic     ack;
   logic     err;
   int       lat;
   host_xfer(reg_adr(idx), 1'b1, dat, sel, rdat, ack, err, lat);
   check_flag("wbm_ack_o", ack, 1'b1);
   check_flag("wbm_err_o", err, 1'b0);
   if (lat != 3)
      note_failure($sformatf("local write answered after %0d cycles, expected 3", lat));
endtask

task automatic reg_read(input reg_idx_t idx, input wb_data_t exp);
   wb_data_t rdat;
   logic     ack;
   logic     err;
   int       lat;
   host_xfer(reg_adr(idx), 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_ack_o", ack, 1'b1);
   check_flag("wbm_err_o", err, 1'b0);
   check_data("wbm_dat_o", rdat, exp);
   if (lat != 3)
      note_failure($sformatf("local read answered after %0d cycles, expected 3", lat));
endtask

task automatic read_reset_values();
   $display("test 1: reset values");
   check_flag("wbm_ack_o", wbm_ack_o, 1'b0);
   check_flag("wbm_err_o", wbm_err_o, 1'b0);
   check_flag("wbs_cyc_o", wbs_cyc_o, 1'b0);
   check_flag("wbs_stb_o", wbs_stb_o, 1'b0);
   check_flag("wbd_int_rst_n_o", wbd_int_rst_n_o, 1'b0);   // blocks held in reset
   check_flag("bist_rst_n_o", bist_rst_n_o, 1'b0);
   check_flag("mac_rst_n_o", mac_rst_n_o, 1'b0);
   check_data("cfg_clk_ctrl1_o", cfg_clk_ctrl1_o, 32'h0);
   check_data("cfg_clk_ctrl2_o", cfg_clk_ctrl2_o, 32'h0);
   reg_read(IDX_GLB, 32'h0);
   reg_read(IDX_BANK, 32'h0000_1000);
   reg_read(IDX_CLK1, 32'h0);
   reg_read(IDX_CLK2, 32'h0);
endtask

task automatic exercise_local_regs();
   wb_data_t glb;   // expected global control
   wb_data_t dat;
   $display("test 2: local write and read");
   glb = 32'h0000_0007;
   reg_write(IDX_GLB, glb, 4'hF);
   reg_read(IDX_GLB, glb);
   check_flag("wbd_int_rst_n_o", wbd_int_rst_n_o, 1'b1);
   check_flag("bist_rst_n_o", bist_rst_n_o, 1'b1);
   check_flag("mac_rst_n_o", mac_rst_n_o, 1'b1);
   // lanes 3 and 1 only
   dat = 32'hAABB_CC02;
   glb = {dat[31:24], glb[23:16], dat[15:8], glb[7:0]};
   reg_write(IDX_GLB, dat, 4'b1010);
   reg_read(IDX_GLB, glb);
   dat = 32'h1122_3305;
   glb = {glb[31:8], dat[7:0]};   // lane 0 only with bits 2:0 = 101
   reg_write(IDX_GLB, dat, 4'b0001);
   reg_read(IDX_GLB, glb);
   check_flag("wbd_int_rst_n_o", wbd_int_rst_n_o, 1'b1);
   check_flag("bist_rst_n_o", bist_rst_n_o, 1'b0);
   check_flag("mac_rst_n_o", mac_rst_n_o, 1'b1);
   // clock words take the whole word whatever the byte enables
   reg_write(IDX_CLK1, 32'h1234_5678, 4'b0011);
   reg_write(IDX_CLK2, 32'h9ABC_DEF0, 4'b1000);
   reg_read(IDX_CLK1, 32'h1234_5678);
   reg_read(IDX_CLK2, 32'h9ABC_DEF0);
   check_data("cfg_clk_ctrl1_o", cfg_clk_ctrl1_o, 32'h1234_5678);
   check_data("cfg_clk_ctrl2_o", cfg_clk_ctrl2_o, 32'h9ABC_DEF0);
   @(posedge wbm_clk_i);
   #2;
   check_flag("wbm_ack_o", wbm_ack_o, 1'b0);               // one-cycle ack
   check_data("wbm_dat_o", wbm_dat_o, 32'h9ABC_DEF0);      // read data held
endtask

task automatic access_banked_window();
   bank_sel_t bank;
   wb_addr_t  hadr;
   wb_addr_t  exp_adr;   // {bank[15:2], host[17:0]}
   wb_data_t  rdat;
   logic      ack;
   logic      err;
   int        lat;
   $display("test 3: banked downstream access");
   bank = 16'h2345;
   reg_write(IDX_BANK, 32'hFFFF_2345, 4'hF);   // upper half has no storage
   reg_read(IDX_BANK, 32'h0000_2345);
   hadr    = 32'h0001_2344;
   exp_adr = {bank[15:2], hadr[17:0]};
   host_xfer(hadr, 1'b1, 32'hDEAD_BEEF, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_ack_o", ack, 1'b1);
   check_addr("wbs_adr_o", slv_req.adr, exp_adr);
   check_flag("wbs_we_o", slv_req.we, 1'b1);
   check_data("wbs_dat_o", slv_req.dat, 32'hDEAD_BEEF);
   // host bits 31:20 never reach the slave
   host_xfer(32'h5A01_2344, 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_ack_o", ack, 1'b1);
   check_addr("wbs_adr_o", slv_req.adr, exp_adr);
   check_flag("wbs_we_o", slv_req.we, 1'b0);
   check_data("wbm_dat_o", rdat, 32'hDEAD_BEEF);
   // middle lanes only
   host_xfer(hadr, 1'b1, 32'h1234_5678, 4'b0110, rdat, ack, err, lat);
   check_flag("wbm_ack_o", ack, 1'b1);
   check_sel("wbs_sel_o", slv_req.sel, 4'b0110);
   host_xfer(hadr, 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
   check_data("wbm_dat_o", rdat, 32'hDE34_56EF);
   hadr    = 32'h0003_FFFC;   // unwritten so the slave returns its fill pattern
   exp_adr = {bank[15:2], hadr[17:0]};
   host_xfer(hadr, 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
   check_addr("wbs_adr_o", slv_req.adr, exp_adr);
   check_data("wbm_dat_o", rdat, mem_word(exp_adr));
endtask

task automatic stall_downstream();
   wb_addr_t hadr;
   wb_data_t wdat;
   wb_data_t rdat;
   logic     ack;
   logic     err;
   int       lat;
   $display("test 4: back-pressure");
   slv_wait_max = 12;   // slave model checks stability while waiting
   for (int i = 0; i < 6; i++)
   begin
      hadr = wb_addr_t'($random(seed)) & 32'h0003_FFFC;   // region 00 and word aligned
      wdat = wb_data_t'($random(seed));
      host_xfer(hadr, 1'b1, wdat, 4'hF, rdat, ack, err, lat);
      check_flag("wbm_ack_o", ack, 1'b1);
      if (lat != slv_wait + 2)
         note_failure($sformatf("write took %0d cycles for slave wait %0d", lat, slv_wait));
      host_xfer(hadr, 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
      check_flag("wbm_ack_o", ack, 1'b1);
      check_data("wbm_dat_o", rdat, wdat);
      if (lat != slv_wait + 2)
         note_failure($sformatf("read took %0d cycles for slave wait %0d", lat, slv_wait));
   end
   slv_wait_max = 2;
endtask

task automatic provoke_errors();
   int       req_cnt;
   wb_data_t rdat;
   logic     ack;
   logic     err;
   int       lat;
   $display("test 5: error responses");
   req_cnt = slv_req_cnt;
   host_xfer(RSV_BASE + 32'h10, 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_err_o", err, 1'b1);
   check_flag("wbm_ack_o", ack, 1'b0);
   if (lat != 2)
      note_failure($sformatf("reserved read errored after %0d cycles, expected 2", lat));
   host_xfer(RSV_BASE, 1'b1, 32'h0BAD_0BAD, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_err_o", err, 1'b1);
   check_flag("wbm_ack_o", ack, 1'b0);
   if (slv_req_cnt != req_cnt)
      note_failure("reserved access reached the downstream slave");
   slv_err_next = 1'b1;   // slave rejects the next request
   host_xfer(32'h0000_0100, 1'b1, 32'h5555_AAAA, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_err_o", err, 1'b1);
   check_flag("wbm_ack_o", ack, 1'b0);
   host_xfer(32'h0000_0100, 1'b0, 32'h0, 4'hF, rdat, ack, err, lat);
   check_flag("wbm_ack_o", ack, 1'b1);   // bridge back to normal
   check_flag("wbm_err_o", err, 1'b0);
endtask

/* dv/tb_wbh.sv */
// directed testbench for wbh_top; slave model answers every downstream address, one transfer at a time
`timescale 1ns/1ps

module tb_wbh;

   import wbh_pkg::*;

   localparam int TIMEOUT_CYC = 4000;   // limit for the whole run
   localparam int XFER_LIM    = 100;    // per transfer limit well above the longest slave wait

   logic      wbm_clk_i;
   logic      wbm_rst_n;
   logic      wbm_cyc_i;
   logic      wbm_stb_i;
   wb_addr_t  wbm_adr_i;
   logic      wbm_we_i;
   wb_data_t  wbm_dat_i;
   wb_sel_t   wbm_sel_i;
   wb_data_t  wbm_dat_o;
   logic      wbm_ack_o;
   logic      wbm_err_o;
   logic      wbs_cyc_o;
   logic      wbs_stb_o;
   wb_addr_t  wbs_adr_o;
   logic      wbs_we_o;
   wb_data_t  wbs_dat_o;
   wb_sel_t   wbs_sel_o;
   wb_data_t  wbs_dat_i;
   logic      wbs_ack_i;
   logic      wbs_err_i;
   logic      wbd_int_rst_n_o;
   logic      bist_rst_n_o;
   logic      mac_rst_n_o;
   wb_data_t  cfg_clk_ctrl1_o;
   wb_data_t  cfg_clk_ctrl2_o;

   int          seed    = 54069;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          cycle_cnt;
   wb_data_t    slv_mem [wb_addr_t];   // slave storage keyed by wbs_adr_o
   wb_req_t     slv_req;               // request as captured at strobe
   logic        slv_busy;
   logic        slv_err_next;          // next request gets err instead of ack
   int unsigned slv_wait_max;          // bound of the random wait
   int unsigned slv_wait;              // wait drawn for the last request
   int unsigned slv_left;
   int          slv_req_cnt;           // downstream requests seen

   wbh_top DUT (.*);

   initial
   begin
      wbm_clk_i = 1'b0;
      forever #20 wbm_clk_i = ~wbm_clk_i;   // 40 ns period
   end

   // ------------------------------------------------------------
   // compare and report
   // ------------------------------------------------------------
   task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic check_sel(input string name, input wb_sel_t got, input wb_sel_t exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic note_failure(input string msg);
      err_cnt++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   // unwritten words read a pattern built from the whole address
   function automatic wb_data_t mem_word(input wb_addr_t adr);
      if (slv_mem.exists(adr))
         return slv_mem[adr];
      return {adr[15:0], adr[31:16]} ^ 32'hC3C3_3C3C;
   endfunction

   // one host transfer with the request held until ack or err
   task automatic host_xfer(input wb_addr_t adr, input logic we, input wb_data_t dat,
                            input wb_sel_t sel, output wb_data_t rdat, output logic ack,
                            output logic err, output int lat);
      int n;
      n = 0;
      @(posedge wbm_clk_i);
      #2;
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_adr_i = adr;
      wbm_we_i  = we;
      wbm_dat_i = dat;
      wbm_sel_i = sel;
      while (!wbm_ack_o && !wbm_err_o && n < XFER_LIM)
      begin
         @(posedge wbm_clk_i);
         #2;
         n++;   // edges since the request went out
      end
      ack  = wbm_ack_o;
      err  = wbm_err_o;
      rdat = wbm_dat_o;
      lat  = n;
      wbm_cyc_i = 1'b0;   // drop at the ack so it lasts one cycle
      wbm_stb_i = 1'b0;
      if (n >= XFER_LIM)
         note_failure($sformatf("no acknowledge for host address 0x%08h", adr));
   endtask

   // ------------------------------------------------------------
   // downstream slave model
   // ------------------------------------------------------------
   initial
   begin
      wb_data_t word;
      wbs_ack_i   = 1'b0;
      wbs_err_i   = 1'b0;
      wbs_dat_i   = '0;
      slv_busy    = 1'b0;
      slv_req_cnt = 0;
      forever
      begin
         @(posedge wbm_clk_i);
         #2;
         wbs_ack_i = 1'b0;   // responses are single pulses
         wbs_err_i = 1'b0;
         if (slv_busy)
         begin
            // request must stay put and the host must keep waiting
            check_addr("wbs_adr_o", wbs_adr_o, slv_req.adr);
            check_flag("wbs_we_o", wbs_we_o, slv_req.we);
            check_data("wbs_dat_o", wbs_dat_o, slv_req.dat);
            check_sel("wbs_sel_o", wbs_sel_o, slv_req.sel);
            check_flag("wbs_cyc_o", wbs_cyc_o, 1'b1);
            check_flag("wbs_stb_o", wbs_stb_o, 1'b1);
            check_flag("wbm_ack_o", wbm_ack_o, 1'b0);
         end
         else if (wbs_stb_o)
         begin
            slv_req  = '{adr: wbs_adr_o, we: wbs_we_o, dat: wbs_dat_o, sel: wbs_sel_o};
            slv_wait = $unsigned($random(seed)) % (slv_wait_max + 1);
            slv_left = slv_wait;
            slv_busy = 1'b1;
            slv_req_cnt++;
         end
         if (slv_busy && slv_left != 0)
            slv_left--;
         else if (slv_busy)
         begin
            slv_busy = 1'b0;
            if (slv_err_next)
            begin
               wbs_err_i    = 1'b1;   // nothing stored on error
               slv_err_next = 1'b0;
            end
            else
            begin
               wbs_ack_i = 1'b1;
               word = mem_word(slv_req.adr);
               if (slv_req.we)
               begin
                  for (int b = 0; b < 4; b++)
                  begin
                     if (slv_req.sel[b])
                        word[8*b +: 8] = slv_req.dat[8*b +: 8];   // byte lane
                  end
                  slv_mem[slv_req.adr] = word;
               end
               wbs_dat_i = word;
            end
         end
      end
   end

   `include "tb_wbh_tests.svh"

   // ------------------------------------------------------------
   // timeout and main sequence
   // ------------------------------------------------------------
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC)
      begin
         @(posedge wbm_clk_i);
         cycle_cnt++;
      end
      note_failure($sformatf("run stopped by timeout after %0d cycles", cycle_cnt));
      $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      wbm_rst_n    = 1'b0;
      wbm_cyc_i    = 1'b0;
      wbm_stb_i    = 1'b0;
      wbm_adr_i    = '0;
      wbm_we_i     = 1'b0;
      wbm_dat_i    = '0;
      wbm_sel_i    = '0;
      slv_wait_max = 2;
      slv_err_next = 1'b0;
      repeat (10) @(posedge wbm_clk_i);   // reset for 10 cycles
      #2;
      wbm_rst_n = 1'b1;
      read_reset_values();
      exercise_local_regs();
      access_banked_window();
      stall_downstream();
      provoke_errors();
      $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* hdl/wbh_top.sv */
// wishbone host bridge top; single wbm_clk_i domain, classic cycles only, no pipelining
`timescale 1ns/1ps

module wbh_top (
   input  logic               wbm_clk_i,
   input  logic               wbm_rst_n,
   // host port
   input  logic               wbm_cyc_i,
   input  logic               wbm_stb_i,
   input  wbh_pkg::wb_addr_t  wbm_adr_i,
   input  logic               wbm_we_i,
   input  wbh_pkg::wb_data_t  wbm_dat_i,
   input  wbh_pkg::wb_sel_t   wbm_sel_i,
   output wbh_pkg::wb_data_t  wbm_dat_o,
   output logic               wbm_ack_o,
   output logic               wbm_err_o,
   // downstream slave port
   output logic               wbs_cyc_o,
   output logic               wbs_stb_o,
   output wbh_pkg::wb_addr_t  wbs_adr_o,
   output logic               wbs_we_o,
   output wbh_pkg::wb_data_t  wbs_dat_o,
   output wbh_pkg::wb_sel_t   wbs_sel_o,
   input  wbh_pkg::wb_data_t  wbs_dat_i,
   input  logic               wbs_ack_i,
   input  logic               wbs_err_i,
   // config outputs
   output logic               wbd_int_rst_n_o,
   output logic               bist_rst_n_o,
   output logic               mac_rst_n_o,
   output wbh_pkg::wb_data_t  cfg_clk_ctrl1_o,
   output wbh_pkg::wb_data_t  cfg_clk_ctrl2_o
);

   import wbh_pkg::*;

   wb_req_t   host_req;   // raw host fields
   wb_req_t   req;        // registered request
   logic      req_vld;
   logic      reg_cs;
   wb_rsp_t   reg_rsp;    // from local registers
   wb_rsp_t   rsp;        // selected, back to host
   bank_sel_t bank_sel;

   assign host_req.adr = wbm_adr_i;
   assign host_req.we  = wbm_we_i;
   assign host_req.dat = wbm_dat_i;
   assign host_req.sel = wbm_sel_i;

   // ------------------------------------------------------------
   // host register, router, local registers
   // ------------------------------------------------------------
   wbh_req_stage u_req_stage (
      .wbm_clk_i  (wbm_clk_i),
      .wbm_rst_n  (wbm_rst_n),
      .wbm_cyc_i  (wbm_cyc_i),
      .wbm_stb_i  (wbm_stb_i),
      .host_req_i (host_req),
      .rsp_i      (rsp),
      .req_vld_o  (req_vld),
      .req_o      (req),
      .wbm_dat_o  (wbm_dat_o),
      .wbm_ack_o  (wbm_ack_o),
      .wbm_err_o  (wbm_err_o)
   );

   wbh_router u_router (
      .req_vld_i  (req_vld),
      .req_i      (req),
      .bank_sel_i (bank_sel),
      .reg_rsp_i  (reg_rsp),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_ack_i  (wbs_ack_i),
      .wbs_err_i  (wbs_err_i),
      .reg_cs_o   (reg_cs),
      .rsp_o      (rsp),
      .wbs_cyc_o  (wbs_cyc_o),
      .wbs_stb_o  (wbs_stb_o),
      .wbs_adr_o  (wbs_adr_o),
      .wbs_we_o   (wbs_we_o),
      .wbs_dat_o  (wbs_dat_o),
      .wbs_sel_o  (wbs_sel_o)
   );

   wbh_regs u_regs (
      .wbm_clk_i       (wbm_clk_i),
      .wbm_rst_n       (wbm_rst_n),
      .reg_cs_i        (reg_cs),
      .req_i           (req),
      .rsp_o           (reg_rsp),
      .bank_sel_o      (bank_sel),
      .wbd_int_rst_n_o (wbd_int_rst_n_o),
      .bist_rst_n_o    (bist_rst_n_o),
      .mac_rst_n_o     (mac_rst_n_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

endmodule

/* hdl/wbh_regs.sv */
// local config words; byte enables apply only to global control and accesses never error
`timescale 1ns/1ps

module wbh_regs (
   input  logic               wbm_clk_i,
   input  logic               wbm_rst_n,
   input  logic               reg_cs_i,          // local select from router
   input  wbh_pkg::wb_req_t   req_i,             // registered request
   output wbh_pkg::wb_rsp_t   rsp_o,             // registered read data and ack
   output wbh_pkg::bank_sel_t bank_sel_o,        // upper downstream address
   output logic               wbd_int_rst_n_o,   // fabric reset, active low
   output logic               bist_rst_n_o,      // bist reset, active low
   output logic               mac_rst_n_o,       // mac reset, active low
   output wbh_pkg::wb_data_t  cfg_clk_ctrl1_o,
   output wbh_pkg::wb_data_t  cfg_clk_ctrl2_o
);

   import wbh_pkg::*;

   reg_idx_t  reg_idx;     // word index from address
   logic      reg_acc;     // access accepted this cycle
   logic      reg_wr;      // write strobe
   logic      reg_ack;     // registered ack
   wb_data_t  glb_ctrl;    // word 0
   bank_sel_t bank_sel;    // word 1
   wb_data_t  clk_ctrl1;   // word 2
   wb_data_t  clk_ctrl2;   // word 3
   wb_data_t  rd_mux;      // read mux out
   wb_data_t  rd_dat;      // read data register

   assign reg_idx = req_i.adr[REG_IDX_LSB +: $bits(reg_idx_t)];
   // select stays up through the ack cycle so take it only once
   assign reg_acc = reg_cs_i & !reg_ack;
   assign reg_wr  = reg_acc & req_i.we;

   // ------------------------------------------------------------
   // config words
   // ------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl <= '0;   // all blocks held in reset
      end
      else if (reg_wr && (reg_idx == IDX_GLB))
      begin
         for (int b = 0; b < WB_SW; b++)
         begin
            if (req_i.sel[b])
               glb_ctrl[8*b +: 8] <= req_i.dat[8*b +: 8];   // per byte lane
         end
      end
   end

   // remaining words are written whole and ignore byte enables
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         bank_sel  <= BANK_RST;
         clk_ctrl1 <= '0;
         clk_ctrl2 <= '0;
      end
      else if (reg_wr)
      begin
         case (reg_idx)
            IDX_BANK : bank_sel  <= req_i.dat[BANK_W-1:0];
            IDX_CLK1 : clk_ctrl1 <= req_i.dat;
            IDX_CLK2 : clk_ctrl2 <= req_i.dat;
            default  : ;   // global control handled above
         endcase
      end
   end

   // ------------------------------------------------------------
   // read path and ack
   // ------------------------------------------------------------
   always_comb
   begin
      case (reg_idx)
         IDX_GLB  : rd_mux = glb_ctrl;
         IDX_BANK : rd_mux = {{(WB_DW-BANK_W){1'b0}}, bank_sel};   // zero extend
         IDX_CLK1 : rd_mux = clk_ctrl1;
         default  : rd_mux = clk_ctrl2;
      endcase
   end

   always_ff @(posedge wbm_clk_i)
   begin
      if (reg_acc)
         rd_dat <= rd_mux;
   end

   // one ack per access for reads and writes alike
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         reg_ack <= 1'b0;
      else
         reg_ack <= reg_acc;
   end

   assign rsp_o.dat = rd_dat;
   assign rsp_o.ack = reg_ack;
   assign rsp_o.err = 1'b0;   // nothing to reject locally

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------
   assign bank_sel_o      = bank_sel;
   assign wbd_int_rst_n_o = glb_ctrl[RST_BIT_WBD];
   assign bist_rst_n_o    = glb_ctrl[RST_BIT_BIST];
   assign mac_rst_n_o     = glb_ctrl[RST_BIT_MAC];
   assign cfg_clk_ctrl1_o = clk_ctrl1;
   assign cfg_clk_ctrl2_o = clk_ctrl2;

   // select must drop once the ack is out or the access repeats
   cs_drop_a : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      reg_ack |=> !reg_cs_i)
      else $error("wbh_regs: select still up after ack");

endmodule

/* hdl/wbh_router.sv */
// region decode and response select; combinational only and slave responses count only while strobed
`timescale 1ns/1ps

module wbh_router (
   input  logic               req_vld_i,     // registered request valid
   input  wbh_pkg::wb_req_t   req_i,         // registered request
   input  wbh_pkg::bank_sel_t bank_sel_i,    // upper address bank
   input  wbh_pkg::wb_rsp_t   reg_rsp_i,     // local register response
   input  wbh_pkg::wb_data_t  wbs_dat_i,     // slave read data
   input  logic               wbs_ack_i,
   input  logic               wbs_err_i,
   output logic               reg_cs_o,      // local register select
   output wbh_pkg::wb_rsp_t   rsp_o,         // selected response
   output logic               wbs_cyc_o,
   output logic               wbs_stb_o,
   output wbh_pkg::wb_addr_t  wbs_adr_o,     // banked address
   output logic               wbs_we_o,
   output wbh_pkg::wb_data_t  wbs_dat_o,
   output wbh_pkg::wb_sel_t   wbs_sel_o
);

   import wbh_pkg::*;

   localparam int HI_ADR_W = WB_AW - LOW_ADR_W;   // bits taken from bank select

   logic [RGN_W-1:0] rgn;       // region code from adr 19:18
   logic             reg_hit;   // local register space
   logic             rsv_hit;   // reserved space
   logic             dn_req;    // live downstream request

   assign rgn = req_i.adr[LOW_ADR_W +: RGN_W];

   // ------------------------------------------------------------
   // downstream request fields
   // ------------------------------------------------------------
   // {bank_sel[15:2], adr[17:0]} reaches past the 256 KB host window
   assign wbs_adr_o = {bank_sel_i[BANK_W-1 -: HI_ADR_W], req_i.adr[LOW_ADR_W-1:0]};
   assign wbs_we_o  = req_i.we;
   assign wbs_dat_o = req_i.dat;
   assign wbs_sel_o = req_i.sel;

   // ------------------------------------------------------------
   // decode and response mux
   // ------------------------------------------------------------
   always_comb
   begin
      reg_hit = (rgn == REG_RGN);
      rsv_hit = (rgn == RSV_RGN);
      dn_req  = req_vld_i & !reg_hit & !rsv_hit;

      reg_cs_o  = req_vld_i & reg_hit;
      wbs_cyc_o = dn_req;   // one cycle per transfer and no bursts
      wbs_stb_o = dn_req;

      rsp_o = '0;
      if (reg_hit)
      begin
         // local space never errors
         rsp_o.dat = reg_rsp_i.dat;
         rsp_o.ack = reg_rsp_i.ack;
      end
      else if (rsv_hit)
      begin
         rsp_o.err = req_vld_i;   // immediate error as nothing sits behind it
      end
      else
      begin
         rsp_o.dat = wbs_dat_i;
         rsp_o.ack = wbs_ack_i & dn_req;   // ignore stray slave responses
         rsp_o.err = wbs_err_i & dn_req;
      end
   end

endmodule

/* hdl/wbh_req_stage.sv */
// host request register; host must hold cyc/stb and fields until ack or err, one transfer at a time
`timescale 1ns/1ps

module wbh_req_stage (
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              wbm_cyc_i,     // host cycle
   input  logic              wbm_stb_i,     // host strobe
   input  wbh_pkg::wb_req_t  host_req_i,    // raw host fields
   input  wbh_pkg::wb_rsp_t  rsp_i,         // selected response from router
   output logic              req_vld_o,     // registered, qualified strobe
   output wbh_pkg::wb_req_t  req_o,         // registered request fields
   output wbh_pkg::wb_data_t wbm_dat_o,     // read data to host, held after ack
   output logic              wbm_ack_o,
   output logic              wbm_err_o
);

   import wbh_pkg::*;

   logic host_stb;    // strobe qualified with cycle
   logic rsp_now;     // response coming back this cycle
   logic rsp_last;    // response went out to host last cycle

   assign host_stb = wbm_cyc_i & wbm_stb_i;
   assign rsp_now  = rsp_i.ack | rsp_i.err;
   assign rsp_last = wbm_ack_o | wbm_err_o;

   // ------------------------------------------------------------
   // request side
   // ------------------------------------------------------------
   // host keeps stb up until it sees ack, so mask both the cycle the
   // response arrives and the cycle it is on the host bus
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         req_vld_o <= 1'b0;
      end
      else
      begin
         req_vld_o <= host_stb & !rsp_now & !rsp_last;   // no reissue
      end
   end

   // fields only move while the host strobes, stable under back-pressure
   always_ff @(posedge wbm_clk_i)
   begin
      if (host_stb)
         req_o <= host_req_i;
   end

   // ------------------------------------------------------------
   // response side
   // ------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
         wbm_dat_o <= '0;
      end
      else
      begin
         wbm_ack_o <= rsp_i.ack;   // one extra flop for timing
         wbm_err_o <= rsp_i.err;
         if (rsp_i.ack)
            wbm_dat_o <= rsp_i.dat;   // keep last read data on the bus
      end
   end

   // ack and err come from different targets through the router,
   // the host must never see both
   ack_err_excl_a : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !(wbm_ack_o && wbm_err_o))
      else $error("wbh_req_stage: ack and err high together");

endmodule

/* hdl/wbh_pkg.sv */
// shared defs for the wishbone host bridge; 32-bit classic wishbone only, single clock domain
package wbh_pkg;

   // ------------------------------------------------------------
   // bus widths
   // ------------------------------------------------------------
   localparam int WB_AW = 32;   // host and downstream address
   localparam int WB_DW = 32;   // data word
   localparam int WB_SW = 4;    // one byte enable per byte lane

   // bank select extension
   localparam int BANK_W = 16;
   localparam logic [BANK_W-1:0] BANK_RST = 16'h1000;   // default bank after reset

   // ------------------------------------------------------------
   // address map
   // ------------------------------------------------------------
   // host bits below LOW_ADR_W pass straight through to the slave
   localparam int LOW_ADR_W = 18;
   // region code sits just above the pass-through bits (19:18)
   localparam int RGN_W = 2;
   localparam logic [RGN_W-1:0] REG_RGN = 2'b10;   // local config registers
   localparam logic [RGN_W-1:0] RSV_RGN = 2'b11;   // reserved, answers with err

   // word index of the local registers
   localparam int REG_IDX_LSB = 2;   // word aligned

   // ------------------------------------------------------------
   // vector types
   // ------------------------------------------------------------
   typedef logic [WB_AW-1:0]  wb_addr_t;
   typedef logic [WB_DW-1:0]  wb_data_t;
   typedef logic [WB_SW-1:0]  wb_sel_t;
   typedef logic [BANK_W-1:0] bank_sel_t;
   typedef logic [1:0]        reg_idx_t;   // four local words

   // local register indices
   localparam reg_idx_t IDX_GLB  = 2'd0;   // global control
   localparam reg_idx_t IDX_BANK = 2'd1;   // bank select
   localparam reg_idx_t IDX_CLK1 = 2'd2;   // clock control 1
   localparam reg_idx_t IDX_CLK2 = 2'd3;   // clock control 2

   // global control bits that drive the block resets
   // all active low, so a cleared bit holds that block in reset
   localparam int RST_BIT_WBD  = 0;   // internal wishbone fabric
   localparam int RST_BIT_BIST = 1;   // bist block
   localparam int RST_BIT_MAC  = 2;   // mac block

   // ------------------------------------------------------------
   // request and response bundles
   // ------------------------------------------------------------
   // one request beat as seen after the host register, 69 bits
   typedef struct packed {
      wb_addr_t adr;   // byte address
      logic     we;    // 1 = write
      wb_data_t dat;   // write data
      wb_sel_t  sel;   // byte enables
   } wb_req_t;

   // response from any target, 34 bits
   // ack and err are single-cycle pulses, never together
   typedef struct packed {
      wb_data_t dat;   // read data, valid with ack
      logic     ack;
      logic     err;
   } wb_rsp_t;

endpackage
